// File: files.f
design/qspi_pkg.sv
design/qspi_sck_gen.sv
design/qspi_sequencer.sv
design/qspi_tx_slicer.sv
design/qspi_rx_shifter.sv
design/qspi_cfg_regs.sv
design/qspi_ctrl.sv
bench/qspi_mem_model.sv
bench/qspi_tb.sv

// File: run.sh
#!/bin/sh
# build and run the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module qspi_tb -f files.f -o qspi_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/qspi_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation returned an error status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
	exit 0
fi
exit 1

// File: bench/qspi_tb.sv
// ##########################################################################
// directed testbench for the quad-SPI memory controller
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module qspi_tb;
	import qspi_pkg::*;

	// longest transaction is about 40 SCK periods of 14 clocks
	localparam int xfer_limit = 20000;

	logic                 clk;
	logic                 rst_n;
	logic                 read_req;
	logic                 write_req;
	size_t                req_size;
	logic [addr_w-1:0]    req_adr;
	logic [data_w-1:0]    write_data;
	logic                 read_valid;
	logic [data_w-1:0]    read_data;
	logic                 write_finish;
	logic                 reg_we;
	logic [reg_adr_w-1:0] reg_wadr;
	logic [data_w-1:0]    reg_wdata;
	logic                 reg_re;
	logic [reg_adr_w-1:0] reg_radr;
	logic [data_w-1:0]    reg_rdata;
	logic                 sck;
	logic [num_ce-1:0]    ce_n;
	logic [3:0]           sio_i;
	logic [3:0]           sio_o;
	logic                 sio_en;

	logic [7:0]           cur_rdcmd;
	logic [7:0]           cur_wrcmd;
	logic [lat_w-1:0]     cur_lat [3];
	logic                 cur_rd;
	logic                 ce_clear;
	logic [num_ce-1:0]    ce_seen;
	int                   rise_idx;

	qspi_ctrl dut_i (
		.clk, .rst_n,
		.read_req, .write_req, .req_size, .req_adr, .write_data,
		.read_valid, .read_data, .write_finish,
		.reg_we, .reg_wadr, .reg_wdata,
		.reg_re, .reg_radr, .reg_rdata,
		.sck, .ce_n, .sio_i, .sio_o, .sio_en
	);

	qspi_mem_model mem_i (
		.sck   (sck),
		.ce_n  (ce_n),
		.sio_o (sio_o),
		.sio_i (sio_i),
		.rdcmd (cur_rdcmd),
		.lat0  (cur_lat[0]),
		.lat1  (cur_lat[1]),
		.lat2  (cur_lat[2])
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// which chip enables went low since the last clear
	always @(posedge clk) begin
		if (ce_clear)
			ce_seen <= '0;
		else
			ce_seen <= ce_seen | ~ce_n;
	end

	task automatic fail_run();
		$display(">>> FAIL");
		$fatal(1, "stopping after first error");
	endtask

	task automatic check_data(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_reg(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: register %s read %h expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_cmd(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s byte %h expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_ce(input logic [num_ce-1:0] got, input logic [num_ce-1:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: chip enables low %b expected %b", $time, got, exp);
			fail_run();
		end
	endtask

	// pins driven only for command, address and write data
	always @(posedge sck) begin
		logic exp_en;
		exp_en = (rise_idx < 8 + adr_nibbles) || !cur_rd;
		if (&ce_n) begin
			rise_idx <= 0;
		end else begin
			check_data({31'd0, sio_en}, {31'd0, exp_en}, "sio_en at SCK rise");
			rise_idx <= rise_idx + 1;
		end
	end

	task automatic reg_write(input logic [reg_adr_w-1:0] a, input logic [data_w-1:0] d);
		@(posedge clk);
		reg_we    <= 1'b1;
		reg_wadr  <= a;
		reg_wdata <= d;
		@(posedge clk);
		reg_we    <= 1'b0;
	endtask

	task automatic reg_read(input logic [reg_adr_w-1:0] a, output logic [data_w-1:0] d);
		@(posedge clk);
		reg_re   <= 1'b1;
		reg_radr <= a;
		@(posedge clk);
		reg_re   <= 1'b0;
		@(posedge clk);
		d = reg_rdata;
	endtask

	task automatic wait_done(input bit rd, output logic [data_w-1:0] data);
		int n;
		n = 0;
		@(posedge clk);
		while (!(rd ? read_valid : write_finish) && n < xfer_limit) begin
			n++;
			@(posedge clk);
		end
		data = read_data;
		if (n >= xfer_limit) begin
			$display("transaction hung: no completion pulse after %0d cycles", xfer_limit);
			fail_run();
		end
	endtask

	task automatic issue(input bit rd, input size_t sz, input logic [addr_w-1:0] adr,
			input logic [data_w-1:0] wd, output logic [data_w-1:0] rdata);
		int n;
		cur_rd = rd;
		@(posedge clk);
		read_req   <= rd;
		write_req  <= !rd;
		req_size   <= sz;
		req_adr    <= adr;
		write_data <= wd;
		ce_clear   <= 1'b1;
		@(posedge clk);
		read_req   <= 1'b0;
		write_req  <= 1'b0;
		ce_clear   <= 1'b0;
		wait_done(rd, rdata);
		// chip enable goes high shortly after completion
		n = 0;
		while (!(&ce_n) && n < 4) begin
			n++;
			@(posedge clk);
		end
		check_ce(~ce_n, '0);
		check_cmd(mem_i.last_cmd, rd ? cur_rdcmd : cur_wrcmd, "command");
		check_ce(ce_seen, num_ce'(1) << adr[25:24]);
	endtask

	function automatic logic [data_w-1:0] size_mask(input size_t sz, input logic [data_w-1:0] w);
		case (sz)
			size_word: return w;
			size_half: return {16'd0, w[15:0]};
			default:   return {24'd0, w[7:0]};
		endcase
	endfunction

	// write, check the model bytes low first, read back
	task automatic write_read(input size_t sz, input logic [1:0] dev);
		logic [addr_w-1:0] adr;
		logic [data_w-1:0] wd;
		logic [data_w-1:0] rd;
		int                nbytes;
		adr    = {dev, 24'($urandom) & 24'hfffffc};
		wd     = $urandom;
		nbytes = (sz == size_word) ? 4 : (sz == size_half) ? 2 : 1;
		issue(1'b0, sz, adr, wd, rd);
		for (int i = 0; i < nbytes; i++)
			check_data({24'd0, mem_i.peek_byte(int'(adr) + i)}, {24'd0, wd[8*i +: 8]},
				"model array byte");
		issue(1'b1, sz, adr, '0, rd);
		check_data(rd, size_mask(sz, wd), "read data");
	endtask

	task automatic set_reg(input logic [reg_adr_w-1:0] a, input logic [data_w-1:0] d);
		logic [data_w-1:0] got;
		reg_write(a, d);
		reg_read(a, got);
		check_reg(got, d, "read-back");
	endtask

	task automatic test_regs();
		logic [data_w-1:0] got;
		reg_read(reg_lat0, got);
		check_reg(got, 32'd7, "lat0 default");
		reg_read(reg_lat1, got);
		check_reg(got, 32'd7, "lat1 default");
		reg_read(reg_lat2, got);
		check_reg(got, 32'd7, "lat2 default");
		reg_read(reg_sckdiv, got);
		check_reg(got, 32'd0, "sckdiv default");
		reg_read(reg_rdcmd, got);
		check_reg(got, 32'heb, "rdcmd default");
		reg_read(reg_wrcmd, got);
		check_reg(got, 32'h38, "wrcmd default");
		set_reg(reg_sckdiv, 32'd3);
		set_reg(reg_lat0, 32'd2);
		set_reg(reg_lat1, 32'd3);
		set_reg(reg_lat2, 32'd1);
		cur_lat[0] = 4'd2;
		cur_lat[1] = 4'd3;
		cur_lat[2] = 4'd1;
	endtask

	task automatic test_cmds();
		set_reg(reg_rdcmd, 32'h6b);
		set_reg(reg_wrcmd, 32'h32);
		set_reg(reg_lat1, 32'd5);
		cur_rdcmd  = 8'h6b;
		cur_wrcmd  = 8'h32;
		cur_lat[1] = 4'd5;
		write_read(size_word, 2'd1);
		write_read(size_byte, 2'd1);
	endtask

	task automatic test_divider();
		logic prev;
		int   n;
		set_reg(reg_sckdiv, 32'd6);
		repeat (40) @(posedge clk);
		prev = sck;
		n    = 0;
		@(posedge clk);
		while (sck == prev && n < 100) begin
			n++;
			@(posedge clk);
		end
		prev = sck;
		n    = 0;
		while (sck == prev && n < 100) begin
			n++;
			@(posedge clk);
		end
		check_data(32'(n), 32'd7, "SCK half period");
		write_read(size_word, 2'd0);
	endtask

	initial begin
		void'($urandom(92396));
		rst_n      = 1'b0;
		read_req   = 1'b0;
		write_req  = 1'b0;
		req_size   = size_word;
		req_adr    = '0;
		write_data = '0;
		reg_we     = 1'b0;
		reg_wadr   = '0;
		reg_wdata  = '0;
		reg_re     = 1'b0;
		reg_radr   = '0;
		ce_clear   = 1'b1;
		cur_rd     = 1'b0;
		cur_rdcmd  = rdcmd_default;
		cur_wrcmd  = wrcmd_default;
		for (int i = 0; i < 3; i++)
			cur_lat[i] = lat_default;
		repeat (10) @(posedge clk);
		check_data({31'd0, sck}, 32'd1, "sck during reset");
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		check_ce(ce_n, 3'b111);
		check_data({31'd0, sio_en}, 32'd0, "sio_en after reset");
		check_data({31'd0, read_valid}, 32'd0, "read_valid after reset");
		check_data({31'd0, write_finish}, 32'd0, "write_finish after reset");
		check_data(reg_rdata, 32'd0, "reg_rdata after reset");

		test_regs();
		write_read(size_word, 2'd0);
		write_read(size_half, 2'd1);
		write_read(size_byte, 2'd2);
		write_read(size_half, 2'd2);
		write_read(size_byte, 2'd1);
		test_cmds();
		test_divider();

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/qspi_mem_model.sv
// ##########################################################################
// behavioral quad-SPI memory, decodes pin transactions into a byte array
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module qspi_mem_model (
	input  wire        sck,
	input  wire [2:0]  ce_n,
	input  wire [3:0]  sio_o,
	output logic [3:0] sio_i,
	input  wire [7:0]  rdcmd,
	input  wire [3:0]  lat0,
	input  wire [3:0]  lat1,
	input  wire [3:0]  lat2
);
	logic [7:0]  mem [int];
	logic [7:0]  cmd;
	logic [7:0]  last_cmd;
	logic [23:0] adr;
	logic [1:0]  dev;
	int          rise_cnt;

	initial begin
		sio_i    = 4'd0;
		rise_cnt = 0;
		cmd      = 8'd0;
		last_cmd = 8'd0;
		adr      = 24'd0;
		dev      = 2'd0;
	end

	// unwritten locations return a pattern over the whole address
	function automatic logic [7:0] peek_byte(input int key);
		if (mem.exists(key))
			return mem[key];
		return key[7:0] ^ key[15:8] ^ key[23:16] ^ {6'd0, key[25:24]} ^ 8'h5a;
	endfunction

	function automatic int lat_of(input logic [1:0] d);
		case (d)
			2'd1:    return int'(lat1);
			2'd2:    return int'(lat2);
			default: return int'(lat0);
		endcase
	endfunction

	always @(posedge sck) begin
		int         k;
		int         key;
		logic [7:0] b;
		if (!(&ce_n)) begin
			case (ce_n)
				3'b101:  dev = 2'd1;
				3'b011:  dev = 2'd2;
				default: dev = 2'd0;
			endcase
			if (rise_cnt < 8) begin
				cmd = {cmd[6:0], sio_o[0]};
			end else if (rise_cnt < 14) begin
				adr = {adr[19:0], sio_o};
			end else if (cmd != rdcmd) begin
				// write data, byte k/2, high nibble first
				k   = rise_cnt - 14;
				key = int'({dev, adr}) + k / 2;
				b   = peek_byte(key);
				if (k % 2 == 0)
					b[7:4] = sio_o;
				else
					b[3:0] = sio_o;
				mem[key] = b;
			end
			rise_cnt = rise_cnt + 1;
		end
	end

	// read nibbles change on the falling edge after the dummy period
	always @(negedge sck) begin
		int         k;
		logic [7:0] b;
		if (!(&ce_n) && rise_cnt >= 15 + lat_of(dev) && cmd == rdcmd) begin
			k     = rise_cnt - (15 + lat_of(dev));
			b     = peek_byte(int'({dev, adr}) + k / 2);
			sio_i = (k % 2 == 0) ? b[7:4] : b[3:0];
		end
	end

	always @(ce_n) begin
		if (&ce_n) begin
			if (rise_cnt > 0)
				last_cmd = cmd;
			rise_cnt = 0;
		end
	end

endmodule

`default_nettype wire

// File: design/qspi_ctrl.sv
// ##########################################################################
// quad-SPI memory controller top, request port and register port to pins
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module qspi_ctrl (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire                             read_req,
	input  wire                             write_req,
	input  wire qspi_pkg::size_t            req_size,
	input  wire [qspi_pkg::addr_w-1:0]      req_adr,
	input  wire [qspi_pkg::data_w-1:0]      write_data,
	output logic                            read_valid,
	output logic [qspi_pkg::data_w-1:0]     read_data,
	output logic                            write_finish,
	input  wire                             reg_we,
	input  wire [qspi_pkg::reg_adr_w-1:0]   reg_wadr,
	input  wire [qspi_pkg::data_w-1:0]      reg_wdata,
	input  wire                             reg_re,
	input  wire [qspi_pkg::reg_adr_w-1:0]   reg_radr,
	output logic [qspi_pkg::data_w-1:0]     reg_rdata,
	output logic                            sck,
	output logic [qspi_pkg::num_ce-1:0]     ce_n,
	input  wire [3:0]                       sio_i,
	output logic [3:0]                      sio_o,
	output logic                            sio_en
);
	import qspi_pkg::*;

	logic                 sck_rise;
	logic                 sck_fall;
	logic [sck_div_w-1:0] sck_div;
	logic [lat_w-1:0]     lat0;
	logic [lat_w-1:0]     lat1;
	logic [lat_w-1:0]     lat2;
	logic [7:0]           rdcmd;
	logic [7:0]           wrcmd;

	qs_state_t            state;
	qs_state_t            state_next;
	size_t                word_size;
	logic [addr_w-1:0]    word_adr;
	logic [data_w-1:0]    wdata_lat;
	logic                 word_rd;
	logic                 cmd_done;
	logic                 adr_done;
	logic                 wdat_done;

	qspi_sck_gen sck_gen_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.sck_div  (sck_div),
		.sck      (sck),
		.sck_rise (sck_rise),
		.sck_fall (sck_fall)
	);

	qspi_sequencer sequencer_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.read_req     (read_req),
		.write_req    (write_req),
		.req_size     (req_size),
		.req_adr      (req_adr),
		.write_data   (write_data),
		.sck_fall     (sck_fall),
		.cmd_done     (cmd_done),
		.adr_done     (adr_done),
		.wdat_done    (wdat_done),
		.lat0         (lat0),
		.lat1         (lat1),
		.lat2         (lat2),
		.state        (state),
		.state_next   (state_next),
		.word_size    (word_size),
		.word_adr     (word_adr),
		.wdata_lat    (wdata_lat),
		.word_rd      (word_rd),
		.ce_n         (ce_n),
		.read_valid   (read_valid),
		.write_finish (write_finish)
	);

	qspi_tx_slicer tx_slicer_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.state      (state),
		.state_next (state_next),
		.sck_fall   (sck_fall),
		.word_size  (word_size),
		.word_adr   (word_adr),
		.wdata_lat  (wdata_lat),
		.word_rd    (word_rd),
		.rdcmd      (rdcmd),
		.wrcmd      (wrcmd),
		.sio_o      (sio_o),
		.sio_en     (sio_en),
		.cmd_done   (cmd_done),
		.adr_done   (adr_done),
		.wdat_done  (wdat_done)
	);

	qspi_rx_shifter rx_shifter_i (
		.clk, .rst_n,
		.state, .state_next,
		.sck_fall, .sck_rise,
		.sio_i, .word_size,
		.read_data
	);

	qspi_cfg_regs cfg_regs_i (
		.clk, .rst_n,
		.reg_we, .reg_wadr, .reg_wdata,
		.reg_re, .reg_radr, .reg_rdata,
		.sck_div,
		.lat0, .lat1, .lat2,
		.rdcmd, .wrcmd
	);

endmodule

`default_nettype wire

// File: design/qspi_cfg_regs.sv
// ##########################################################################
// controller configuration registers with one-cycle read-back
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module qspi_cfg_regs (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire                             reg_we,
	input  wire [qspi_pkg::reg_adr_w-1:0]   reg_wadr,
	input  wire [qspi_pkg::data_w-1:0]      reg_wdata,
	input  wire                             reg_re,
	input  wire [qspi_pkg::reg_adr_w-1:0]   reg_radr,
	output logic [qspi_pkg::data_w-1:0]     reg_rdata,
	output logic [qspi_pkg::sck_div_w-1:0]  sck_div,
	output logic [qspi_pkg::lat_w-1:0]      lat0,
	output logic [qspi_pkg::lat_w-1:0]      lat1,
	output logic [qspi_pkg::lat_w-1:0]      lat2,
	output logic [7:0]                      rdcmd,
	output logic [7:0]                      wrcmd
);
	import qspi_pkg::*;

	logic                 rd_vld;
	logic [reg_adr_w-1:0] rd_sel;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lat0    <= lat_default;
			lat1    <= lat_default;
			lat2    <= lat_default;
			sck_div <= sck_div_default;
			rdcmd   <= rdcmd_default;
			wrcmd   <= wrcmd_default;
		end else if (reg_we) begin
			case (reg_wadr)
				reg_lat0:   lat0    <= reg_wdata[lat_w-1:0];
				reg_lat1:   lat1    <= reg_wdata[lat_w-1:0];
				reg_lat2:   lat2    <= reg_wdata[lat_w-1:0];
				reg_sckdiv: sck_div <= reg_wdata[sck_div_w-1:0];
				reg_rdcmd:  rdcmd   <= reg_wdata[7:0];
				reg_wrcmd:  wrcmd   <= reg_wdata[7:0];
				default:    ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_vld <= 1'b0;
		else
			rd_vld <= reg_re;
	end

	always_ff @(posedge clk) begin
		if (reg_re)
			rd_sel <= reg_radr;
	end

	// zero outside the read-back cycle
	always_comb begin
		reg_rdata = '0;
		if (rd_vld) begin
			case (rd_sel)
				reg_lat0:   reg_rdata[lat_w-1:0]     = lat0;
				reg_lat1:   reg_rdata[lat_w-1:0]     = lat1;
				reg_lat2:   reg_rdata[lat_w-1:0]     = lat2;
				reg_sckdiv: reg_rdata[sck_div_w-1:0] = sck_div;
				reg_rdcmd:  reg_rdata[7:0]           = rdcmd;
				reg_wrcmd:  reg_rdata[7:0]           = wrcmd;
				default:    reg_rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/qspi_rx_shifter.sv
// ##########################################################################
// sio input synchronizer and read-data nibble shifter
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module qspi_rx_shifter (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire qspi_pkg::qs_state_t        state,
	input  wire qspi_pkg::qs_state_t        state_next,
	input  wire                             sck_fall,
	input  wire                             sck_rise,
	input  wire [3:0]                       sio_i,
	input  wire qspi_pkg::size_t            word_size,
	output logic [qspi_pkg::data_w-1:0]     read_data
);
	import qspi_pkg::*;

	logic [3:0]        sync0;
	logic [3:0]        sync1;
	logic [3:0]        sync2;
	logic [data_w-1:0] shift;
	size_t             rd_size;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync0 <= 4'd0;
			sync1 <= 4'd0;
			sync2 <= 4'd0;
		end else begin
			sync0 <= sio_i;
			sync1 <= sync0;
			sync2 <= sync1;
		end
	end

	// size is held so read_data stays put across later writes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shift   <= '0;
			rd_size <= size_byte;
		end else if (sck_fall && state != qs_rddat && state_next == qs_rddat) begin
			shift   <= '0;
			rd_size <= word_size;
		end else if (sck_rise && state == qs_rddat) begin
			shift   <= {shift[data_w-5:0], sync2};
		end
	end

	// first byte received lands in bits 7:0
	always_comb begin
		case (rd_size)
			size_word: read_data = {shift[7:0], shift[15:8], shift[23:16], shift[31:24]};
			size_half: read_data = {16'd0, shift[7:0], shift[15:8]};
			default:   read_data = {24'd0, shift[7:0]};
		endcase
	end

endmodule

`default_nettype wire

// File: design/qspi_tx_slicer.sv
// ##########################################################################
// command, address and write-data slicer driving the sio output pins
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module qspi_tx_slicer (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire qspi_pkg::qs_state_t        state,
	input  wire qspi_pkg::qs_state_t        state_next,
	input  wire                             sck_fall,
	input  wire qspi_pkg::size_t            word_size,
	input  wire [qspi_pkg::addr_w-1:0]      word_adr,
	input  wire [qspi_pkg::data_w-1:0]      wdata_lat,
	input  wire                             word_rd,
	input  wire [7:0]                       rdcmd,
	input  wire [7:0]                       wrcmd,
	output logic [3:0]                      sio_o,
	output logic                            sio_en,
	output logic                            cmd_done,
	output logic                            adr_done,
	output logic                            wdat_done
);
	import qspi_pkg::*;

	logic [2:0]        cmd_ofs;
	logic [2:0]        adr_ofs;
	logic [2:0]        wdat_ofs;
	logic [2:0]        wdat_len;
	logic [data_w-1:0] wdata_ext;
	logic [7:0]        cmd_byte;
	logic [4:0]        wsel;

	// data left-aligned so the count always ends on the top byte
	always_comb begin
		case (word_size)
			size_word: begin
				wdata_ext = wdata_lat;
				wdat_len  = 3'd7;
			end
			size_half: begin
				wdata_ext = {wdata_lat[15:0], 16'd0};
				wdat_len  = 3'd3;
			end
			default: begin
				wdata_ext = {wdata_lat[7:0], 24'd0};
				wdat_len  = 3'd1;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_ofs  <= '0;
			adr_ofs  <= '0;
			wdat_ofs <= '0;
		end else if (sck_fall) begin
			if (state != qs_cmd && state_next == qs_cmd)
				cmd_ofs <= 3'd7;
			else if (state == qs_cmd)
				cmd_ofs <= cmd_ofs - 1'b1;
			if (state != qs_adr && state_next == qs_adr)
				adr_ofs <= 3'(adr_nibbles - 1);
			else if (state == qs_adr)
				adr_ofs <= adr_ofs - 1'b1;
			if (state != qs_wdat && state_next == qs_wdat)
				wdat_ofs <= wdat_len;
			else if (state == qs_wdat)
				wdat_ofs <= wdat_ofs - 1'b1;
		end
	end

	assign cmd_done  = sck_fall && state == qs_cmd && cmd_ofs == '0;
	assign adr_done  = sck_fall && state == qs_adr && adr_ofs == '0;
	assign wdat_done = sck_fall && state == qs_wdat && wdat_ofs == '0;

	assign cmd_byte = word_rd ? rdcmd : wrcmd;
	// low byte first, high nibble first within a byte
	assign wsel = {~wdat_ofs[2:1], wdat_ofs[0], 2'b00};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sio_o  <= 4'd0;
			sio_en <= 1'b0;
		end else begin
			sio_en <= state inside {qs_cmd, qs_adr, qs_wdat};
			case (state)
				qs_cmd:  sio_o <= {3'b000, cmd_byte[cmd_ofs]};
				qs_adr:  sio_o <= word_adr[{adr_ofs, 2'b00} +: 4];
				qs_wdat: sio_o <= wdata_ext[wsel +: 4];
				default: sio_o <= 4'd0;
			endcase
		end
	end

	// pins released at every SCK fall of the read phases
	a_rd_no_drive: assert property (@(posedge clk) disable iff (!rst_n)
		(sck_fall && (state == qs_rdwait || state == qs_rddat))
		|-> (!sio_en && sio_o == 4'd0));

endmodule

`default_nettype wire

// File: design/qspi_sequencer.sv
// ##########################################################################
// request sampler, transaction FSM, wait/read counters and chip enables
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module qspi_sequencer (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire                             read_req,
	input  wire                             write_req,
	input  wire qspi_pkg::size_t            req_size,
	input  wire [qspi_pkg::addr_w-1:0]      req_adr,
	input  wire [qspi_pkg::data_w-1:0]      write_data,
	input  wire                             sck_fall,
	input  wire                             cmd_done,
	input  wire                             adr_done,
	input  wire                             wdat_done,
	input  wire [qspi_pkg::lat_w-1:0]       lat0,
	input  wire [qspi_pkg::lat_w-1:0]       lat1,
	input  wire [qspi_pkg::lat_w-1:0]       lat2,
	output qspi_pkg::qs_state_t             state,
	output qspi_pkg::qs_state_t             state_next,
	output qspi_pkg::size_t                 word_size,
	output logic [qspi_pkg::addr_w-1:0]     word_adr,
	output logic [qspi_pkg::data_w-1:0]     wdata_lat,
	output logic                            word_rd,
	output logic [qspi_pkg::num_ce-1:0]     ce_n,
	output logic                            read_valid,
	output logic                            write_finish
);
	import qspi_pkg::*;

	logic             busy;
	logic [lat_w-1:0] lat_sel;
	logic [lat_w-1:0] wait_cnt;
	logic [2:0]       rd_cnt;
	logic [2:0]       rd_len;
	logic             wait_end;
	logic             rd_end;
	logic [1:0]       dev;

	assign dev = word_adr[addr_w-1 -: 2];

	// request sampler, read wins over write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			word_rd <= 1'b0;
		end else if (read_req || write_req) begin
			busy    <= 1'b1;
			word_rd <= read_req;
		end else if (read_valid || write_finish) begin
			busy    <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (read_req || write_req) begin
			word_size <= req_size;
			word_adr  <= req_adr;
		end
		if (write_req)
			wdata_lat <= write_data;
	end

	always_comb begin
		case (state)
			qs_idle:   state_next = busy ? qs_cmd : qs_idle;
			qs_cmd:    state_next = cmd_done ? qs_adr : qs_cmd;
			qs_adr: begin
				if (adr_done)
					state_next = word_rd ? qs_rdwait : qs_wdat;
				else
					state_next = qs_adr;
			end
			qs_wdat:   state_next = wdat_done ? qs_idle : qs_wdat;
			qs_rdwait: state_next = wait_end ? qs_rddat : qs_rdwait;
			qs_rddat:  state_next = rd_end ? qs_idle : qs_rddat;
			default:   state_next = qs_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= qs_idle;
		else if (sck_fall)
			state <= state_next;
	end

	assign lat_sel = (dev == 2'd1) ? lat1 : (dev == 2'd2) ? lat2 : lat0;

	always_comb begin
		case (word_size)
			size_word: rd_len = 3'd7;
			size_half: rd_len = 3'd3;
			default:   rd_len = 3'd1;
		endcase
	end

	// dummy period is latency+1 SCK periods
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt <= '0;
			rd_cnt   <= '0;
		end else if (sck_fall) begin
			if (state != qs_rdwait && state_next == qs_rdwait)
				wait_cnt <= lat_sel;
			else if (state == qs_rdwait && wait_cnt != '0)
				wait_cnt <= wait_cnt - 1'b1;
			if (state != qs_rddat && state_next == qs_rddat)
				rd_cnt <= rd_len;
			else if (state == qs_rddat && rd_cnt != '0)
				rd_cnt <= rd_cnt - 1'b1;
		end
	end

	assign wait_end     = sck_fall && state == qs_rdwait && wait_cnt == '0;
	assign rd_end       = sck_fall && state == qs_rddat && rd_cnt == '0;
	assign read_valid   = rd_end;
	assign write_finish = wdat_done;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ce_n <= '1;
		else if (state == qs_idle)
			ce_n <= '1;
		else
			ce_n <= ~({{(num_ce-1){1'b0}}, 1'b1} << dev);
	end

	a_ce_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(~ce_n));

	a_req_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(read_req || write_req) |-> (state == qs_idle && !busy));

	a_dev_range: assert property (@(posedge clk) disable iff (!rst_n)
		(state != qs_idle) |-> (dev != 2'd3));

endmodule

`default_nettype wire

// File: design/qspi_sck_gen.sv
// ##########################################################################
// SCK divider with one-clock-late rise and fall edge detect
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module qspi_sck_gen (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire [qspi_pkg::sck_div_w-1:0]   sck_div,
	output logic                            sck,
	output logic                            sck_rise,
	output logic                            sck_fall
);
	import qspi_pkg::*;

	logic [sck_div_w-1:0] cnt;
	logic                 sck_d;

	// half period is sck_div+1 clocks, sck idles high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			sck <= 1'b1;
		end else if (cnt >= sck_div) begin
			cnt <= '0;
			sck <= ~sck;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sck_d <= 1'b1;
		else
			sck_d <= sck;
	end

	assign sck_rise = sck & ~sck_d;
	assign sck_fall = ~sck & sck_d;

endmodule

`default_nettype wire

// File: design/qspi_pkg.sv
// ##########################################################################
// quad-SPI controller shared widths, phase encodings and register defaults
// ##########################################################################
`default_nettype none

package qspi_pkg;

	localparam int addr_w      = 26;
	localparam int data_w      = 32;
	localparam int sck_div_w   = 10;
	localparam int lat_w       = 4;
	localparam int num_ce      = 3;
	localparam int reg_adr_w   = 4;
	localparam int adr_nibbles = 6;

	typedef enum logic [1:0] {
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} size_t;

	typedef enum logic [2:0] {
		qs_idle   = 3'd0,
		qs_cmd    = 3'd1,
		qs_adr    = 3'd2,
		qs_wdat   = 3'd3,
		qs_rdwait = 3'd4,
		qs_rddat  = 3'd5
	} qs_state_t;

	// register offsets
	localparam logic [reg_adr_w-1:0] reg_lat0   = 4'h0;
	localparam logic [reg_adr_w-1:0] reg_lat1   = 4'h1;
	localparam logic [reg_adr_w-1:0] reg_lat2   = 4'h2;
	localparam logic [reg_adr_w-1:0] reg_sckdiv = 4'h3;
	localparam logic [reg_adr_w-1:0] reg_rdcmd  = 4'h4;
	localparam logic [reg_adr_w-1:0] reg_wrcmd  = 4'h5;

	localparam logic [sck_div_w-1:0] sck_div_default = 10'd0;
	localparam logic [lat_w-1:0]     lat_default     = 4'd7;
	// quad fast read / quad page write
	localparam logic [7:0]           rdcmd_default   = 8'hEB;
	localparam logic [7:0]           wrcmd_default   = 8'h38;

endpackage

`default_nettype wire
